/* audio_mixer_top.f */
+incdir+hdl
hdl/audio_pkg.sv
hdl/audio_fetch_ctrl.sv
hdl/audio_channel.sv
hdl/audio_mix.sv
hdl/audio_pdm_dac.sv
hdl/audio_mixer_top.sv
bench/audio_mixer_asserts.sv
bench/audio_mixer_tb.sv

/* Makefile */
# Verilator build and run of the audio mixer testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -f audio_mixer_top.f \
		--top-module audio_mixer_tb -o audio_mixer_sim
	./obj_dir/audio_mixer_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

/* bench/audio_mixer_tb.sv */
//**************************************************************************
// testbench for the audio mixer top level
//   clock, reset, memory model with random latency, stimulus phases
//   reference functions for memory words and mixer output, checking
//**************************************************************************

`timescale 1ns/100ps
`include "audio_defines.svh"

module audio_mixer_tb;

    localparam int NCHAN = `AUDIO_NCHAN;

    logic clk = 1'b0;
    logic reset_i = 1'b1;
    audio_pkg::chan_cfg_t chan_cfg [NCHAN];
    logic [NCHAN-1:0] reload;
    logic mem_fetch;
    logic mem_ack;
    logic pdm_l;
    logic pdm_r;
    audio_pkg::mem_req_t mem_req;
    audio_pkg::word_t mem_word;
    audio_pkg::dac_t sample_l;
    audio_pkg::dac_t sample_r;

    integer seed = 32'h7c8f992d;
    audio_pkg::mem_req_t fetch_log[$];
    audio_pkg::dac_t obs_l[$];
    int reload_cnt[NCHAN];
    bit log_on;
    bit r_quiet;
    bit mix_on;
    bit busy;
    int lat;
    int stable;
    int mix_checks;
    audio_pkg::sample_t prev[NCHAN];

    audio_mixer_top uut (
        .clk(clk), .reset_i(reset_i), .chan_cfg_i(chan_cfg), .reload_o(reload),
        .mem_fetch_o(mem_fetch), .mem_req_o(mem_req), .mem_ack_i(mem_ack),
        .mem_word_i(mem_word), .sample_l_o(sample_l), .sample_r_o(sample_r),
        .pdm_l_o(pdm_l), .pdm_r_o(pdm_r)
    );

    bind audio_mixer_top audio_mixer_asserts u_asserts (
        .clk(clk), .reset_i(reset_i), .mem_fetch_o(mem_fetch_o), .mem_ack_i(mem_ack_i),
        .mem_req_o(mem_req_o), .reload_o(reload_o)
    );

    always #5 clk = ~clk;

    // memory contents whose high and low bytes always differ
    function automatic audio_pkg::word_t word_of(input audio_pkg::addr_t addr);
        logic [7:0] hi;
        hi = addr[7:0] ^ addr[15:8] ^ 8'h5a;
        return {hi, hi + 8'h33};
    endfunction

    // sum of sample times volume, scaled by 1/128, clipped, offset binary
    function automatic audio_pkg::dac_t ref_mix(input int sum);
        int s;
        s = sum >>> 7;
        if (s > 127) begin
            s = 127;
        end
        if (s < -128) begin
            s = -128;
        end
        return 8'(s + 128);
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic set_chan(input int c, input bit en, input bit tile, input int vl,
                            input int vr, input int per, input int start, input int len);
        chan_cfg[c].enable  = en;
        chan_cfg[c].restart = 1'b0;
        chan_cfg[c].tile    = tile;
        chan_cfg[c].vol_l   = 7'(vl);
        chan_cfg[c].vol_r   = 7'(vr);
        chan_cfg[c].period  = 15'(per);
        chan_cfg[c].start   = 16'(start);
        chan_cfg[c].len     = 15'(len);
    endtask

    task automatic reset_dut();
        reset_i = 1'b1;
        repeat (16) begin
            step(1);
            assert (!mem_fetch && reload == '0 && sample_l == 8'd128 && sample_r == 8'd128)
                else fail_now("outputs not at their reset values during reset");
        end
        reset_i = 1'b0;
    endtask

    // memory model acknowledging 1 to 4 cycles after the fetch is seen
    always @(posedge clk) begin
        #1;
        if (reset_i || mem_ack) begin
            mem_ack = 1'b0;
            busy    = 1'b0;
        end else if (mem_fetch) begin
            if (!busy) begin
                busy = 1'b1;
                lat  = $unsigned($random(seed)) % 4;
            end
            if (lat == 0) begin
                mem_ack  = 1'b1;
                mem_word = word_of(mem_req.addr);
                busy     = 1'b0;
                fetch_log.push_back(mem_req);
            end else begin
                lat--;
            end
        end
    end

    // outputs are compared at the falling edge where they are stable
    always @(negedge clk) begin
        int sl;
        int sr;
        bit same;
        if (log_on && !reset_i) begin
            if (sample_l != obs_l[$]) begin
                obs_l.push_back(sample_l);
            end
            for (int i = 0; i < NCHAN; i++) begin
                reload_cnt[i] += reload[i];
            end
        end
        if (r_quiet) begin
            assert (sample_r == 8'd128) else fail_now($sformatf(
                "mismatch at %0t: sample_r_o got %0d expected 128", $time, sample_r));
        end
        if (mix_on) begin
            same = 1'b1;
            sl = 0;
            sr = 0;
            for (int i = 0; i < NCHAN; i++) begin
                if (uut.sample[i] != prev[i]) begin
                    same = 1'b0;
                end
                prev[i] = uut.sample[i];
                sl += int'(uut.sample[i]) * int'(chan_cfg[i].vol_l);
                sr += int'(uut.sample[i]) * int'(chan_cfg[i].vol_r);
            end
            stable = same ? stable + 1 : 0;
            if (stable >= 2) begin                  // two-cycle mixer latency covered
                mix_checks++;
                assert (sample_l == ref_mix(sl)) else fail_now($sformatf(
                    "mismatch at %0t: sample_l_o got %0d expected %0d",
                    $time, sample_l, ref_mix(sl)));
                assert (sample_r == ref_mix(sr)) else fail_now($sformatf(
                    "mismatch at %0t: sample_r_o got %0d expected %0d",
                    $time, sample_r, ref_mix(sr)));
            end
        end
    end

    initial begin
        audio_pkg::dac_t exp_l[$];
        audio_pkg::word_t w;
        audio_pkg::dac_t held_l;
        audio_pkg::dac_t held_r;
        int t;
        int ones_l;
        int ones_r;
        mem_ack = 1'b0;
        mem_word = '0;
        for (int i = 0; i < NCHAN; i++) begin
            set_chan(i, 0, 0, 0, 0, 0, 0, 0);
        end
        reset_dut();
        repeat (20) begin
            step(1);
            assert (!mem_fetch && reload == '0 && sample_l == 8'd128 && sample_r == 8'd128)
                else fail_now("activity while all channels are disabled");
        end

        // fetch order and sample sequence of a single channel
        set_chan(0, 1, 1, 127, 0, 40, 'h0100, 3);
        obs_l = {sample_l};
        log_on = 1'b1;
        r_quiet = 1'b1;
        t = 0;
        while (fetch_log.size() < 24 && t < 5000) begin
            step(1);
            t++;
        end
        assert (fetch_log.size() >= 24) else fail_now("timeout waiting for channel 0 fetches");
        foreach (fetch_log[i]) begin
            assert (fetch_log[i].addr == 16'h0100 + i % 4 && fetch_log[i].tile)
                else fail_now($sformatf("mismatch at %0t: mem_req_o got %h expected %h",
                    $time, fetch_log[i], {1'b1, 16'h0100 + 16'(i % 4)}));
        end
        t = reload_cnt[0] - (fetch_log.size() + 3) / 4;
        assert ((t == 0 || t == 1) && reload_cnt[1] == 0)
            else fail_now("reload_o count does not match the number of passes");
        exp_l = {8'd128};
        foreach (fetch_log[i]) begin
            w = word_of(fetch_log[i].addr);
            if (ref_mix(int'($signed(w[15:8])) * 127) != exp_l[$])
                exp_l.push_back(ref_mix(int'($signed(w[15:8])) * 127));
            if (ref_mix(int'($signed(w[7:0])) * 127) != exp_l[$])
                exp_l.push_back(ref_mix(int'($signed(w[7:0])) * 127));
        end
        assert (obs_l.size() >= 8 && obs_l.size() <= exp_l.size())
            else fail_now("too few sample_l_o changes seen");
        foreach (obs_l[i])
            assert (obs_l[i] == exp_l[i]) else fail_now($sformatf(
                "mismatch at %0t: sample_l_o got %0d expected %0d", $time, obs_l[i], exp_l[i]));
        log_on = 1'b0;
        r_quiet = 1'b0;

        // address ownership and mixed output with both channels
        set_chan(0, 0, 0, 0, 0, 0, 0, 0);
        reset_dut();
        fetch_log = {};
        set_chan(0, 1, 1, 100, 30, 20, 'h0100, 3);
        set_chan(1, 1, 0, 90, 120, 33, 'h0200, 2);
        stable = 0;
        mix_on = 1'b1;
        t = 0;
        while ((mix_checks < 300 || fetch_log.size() < 20) && t < 8000) begin
            step(1);
            t++;
        end
        assert (mix_checks >= 300 && fetch_log.size() >= 20)
            else fail_now("timeout waiting for two-channel mixing");
        foreach (fetch_log[i]) begin
            assert ((fetch_log[i].addr inside {[16'h0100:16'h0103]} && fetch_log[i].tile) !=
                    (fetch_log[i].addr inside {[16'h0200:16'h0202]} && !fetch_log[i].tile))
                else fail_now("fetch address belongs to no channel or to both");
        end

        // disable everything
        set_chan(0, 0, 0, 0, 0, 0, 0, 0);
        set_chan(1, 0, 0, 0, 0, 0, 0, 0);
        mix_on = 1'b0;
        t = 0;
        while (mem_fetch && t < 50) begin
            step(1);
            t++;
        end
        assert (!mem_fetch) else fail_now("timeout waiting for the last fetch to finish");
        t = 0;
        while ((sample_l != 8'd128 || sample_r != 8'd128) && t < 10) begin
            step(1);
            t++;
        end
        assert (sample_l == 8'd128 && sample_r == 8'd128)
            else fail_now("outputs did not return to silence");
        step(8);
        fetch_log = {};
        step(200);
        assert (fetch_log.size() == 0) else fail_now("fetch issued with all channels disabled");

        // count the DAC pulses for a steady sample
        reset_dut();
        set_chan(0, 1, 0, 127, 60, 5, 'h0340, 7);
        t = 0;
        while (sample_l == 8'd128 && t < 500) begin
            step(1);
            t++;
        end
        assert (sample_l != 8'd128) else fail_now("timeout waiting for a non-silent sample");
        chan_cfg[0].period = 15'h7fff;          // hold the sample for a long time
        step(20);
        held_l = sample_l;
        held_r = sample_r;
        ones_l = 0;
        ones_r = 0;
        repeat (256) begin
            @(negedge clk);
            ones_l += pdm_l;
            ones_r += pdm_r;
            assert (sample_l == held_l && sample_r == held_r)
                else fail_now("DAC input changed during pulse count");
        end
        assert (ones_l - int'(held_l) <= 1 && int'(held_l) - ones_l <= 1)
            else fail_now($sformatf("mismatch at %0t: pdm_l_o ones got %0d expected %0d",
                $time, ones_l, held_l));
        assert (ones_r - int'(held_r) <= 1 && int'(held_r) - ones_r <= 1)
            else fail_now($sformatf("mismatch at %0t: pdm_r_o ones got %0d expected %0d",
                $time, ones_r, held_r));

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* bench/audio_mixer_asserts.sv */
//**************************************************************************
// memory handshake and reload strobe assertions for the audio mixer
//**************************************************************************

`timescale 1ns/100ps
`include "audio_defines.svh"

module audio_mixer_asserts (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        mem_fetch_o,
    input  logic                        mem_ack_i,
    input  audio_pkg::mem_req_t         mem_req_o,
    input  logic [`AUDIO_NCHAN-1:0]     reload_o
);

    // request held until the memory answers
    hold_until_ack: assert property (@(posedge clk) disable iff (reset_i)
        mem_fetch_o && !mem_ack_i |=> mem_fetch_o && $stable(mem_req_o))
        else $error("fetch or request changed before the acknowledge");

    drop_after_ack: assert property (@(posedge clk) disable iff (reset_i)
        mem_fetch_o && mem_ack_i |=> !mem_fetch_o)
        else $error("fetch still high after the acknowledge");

    reload_strobe: assert property (@(posedge clk) disable iff (reset_i)
        (reload_o & $past(reload_o)) == '0)
        else $error("reload held longer than one cycle");

endmodule

/* hdl/audio_mixer_top.sv */
//**************************************************************************
// audio_mixer_top
//   sample channels sharing one fetch controller
//   volume mixer feeding a left and a right pulse-density DAC
//**************************************************************************

`timescale 1ns/100ps
`include "audio_defines.svh"

module audio_mixer_top (
    input  logic                        clk,
    input  logic                        reset_i,
    input  audio_pkg::chan_cfg_t        chan_cfg_i [`AUDIO_NCHAN],
    output logic [`AUDIO_NCHAN-1:0]     reload_o,
    output logic                        mem_fetch_o,
    output audio_pkg::mem_req_t         mem_req_o,
    input  logic                        mem_ack_i,
    input  audio_pkg::word_t            mem_word_i,
    output audio_pkg::dac_t             sample_l_o,
    output audio_pkg::dac_t             sample_r_o,
    output logic                        pdm_l_o,
    output logic                        pdm_r_o
);

    logic [`AUDIO_NCHAN-1:0] want;
    logic [`AUDIO_NCHAN-1:0] grant;
    audio_pkg::mem_req_t     req [`AUDIO_NCHAN];
    audio_pkg::word_t        word;              // returned word, same for all channels
    audio_pkg::sample_t      sample [`AUDIO_NCHAN];
    audio_pkg::vol_t         vol_l [`AUDIO_NCHAN];
    audio_pkg::vol_t         vol_r [`AUDIO_NCHAN];

    for (genvar i = 0; i < `AUDIO_NCHAN; i++) begin : g_chan
        assign vol_l[i] = chan_cfg_i[i].vol_l;
        assign vol_r[i] = chan_cfg_i[i].vol_r;

        audio_channel u_chan (
            .clk      (clk),
            .reset_i  (reset_i),
            .cfg_i    (chan_cfg_i[i]),
            .grant_i  (grant[i]),
            .word_i   (word),
            .want_o   (want[i]),
            .req_o    (req[i]),
            .sample_o (sample[i]),
            .reload_o (reload_o[i])
        );
    end

    audio_fetch_ctrl u_fetch (
        .clk         (clk),
        .reset_i     (reset_i),
        .want_i      (want),
        .req_i       (req),
        .grant_o     (grant),
        .word_o      (word),
        .mem_fetch_o (mem_fetch_o),
        .mem_req_o   (mem_req_o),
        .mem_ack_i   (mem_ack_i),
        .mem_word_i  (mem_word_i)
    );

    audio_mix u_mix (
        .clk      (clk),
        .reset_i  (reset_i),
        .sample_i (sample),
        .vol_l_i  (vol_l),
        .vol_r_i  (vol_r),
        .out_l_o  (sample_l_o),
        .out_r_o  (sample_r_o)
    );

    audio_pdm_dac u_dac_l (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (sample_l_o),
        .pulse_o (pdm_l_o)
    );

    audio_pdm_dac u_dac_r (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (sample_r_o),
        .pulse_o (pdm_r_o)
    );

endmodule

/* hdl/audio_pdm_dac.sv */
//**************************************************************************
// audio_pdm_dac
//   first-order delta-sigma modulator, one output bit per cycle
//**************************************************************************

`timescale 1ns/100ps
`include "audio_defines.svh"

module audio_pdm_dac (
    input  logic            clk,
    input  logic            reset_i,
    input  audio_pkg::dac_t value_i,
    output logic            pulse_o
);

    logic [`AUDIO_DAC_W:0] acc;     // top bit is the carry out

    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc <= '0;
        end else begin
            acc <= {1'b0, acc[`AUDIO_DAC_W-1:0]} + {1'b0, value_i};
        end
    end

    // density of ones follows value over 256 cycles
    assign pulse_o = acc[`AUDIO_DAC_W];

endmodule

/* hdl/audio_mix.sv */
//**************************************************************************
// audio_mix
//   stage one, per-channel sample times left and right volume
//   stage two, channel sum, scaling, saturation, offset binary
//**************************************************************************

`timescale 1ns/100ps
`include "audio_defines.svh"

module audio_mix (
    input  logic                clk,
    input  logic                reset_i,
    input  audio_pkg::sample_t  sample_i [`AUDIO_NCHAN],
    input  audio_pkg::vol_t     vol_l_i [`AUDIO_NCHAN],
    input  audio_pkg::vol_t     vol_r_i [`AUDIO_NCHAN],
    output audio_pkg::dac_t     out_l_o,
    output audio_pkg::dac_t     out_r_o
);

    localparam int NCHAN  = `AUDIO_NCHAN;
    localparam int PROD_W = 16;
    localparam int SUM_W  = PROD_W + $clog2(NCHAN) + 1;

    logic signed [PROD_W-1:0] prod_l [NCHAN];
    logic signed [PROD_W-1:0] prod_r [NCHAN];
    logic signed [SUM_W-1:0]  sum_l;
    logic signed [SUM_W-1:0]  sum_r;

    // scale back by 128, clip to a signed byte, flip the sign bit
    function automatic audio_pkg::dac_t to_dac(input logic signed [SUM_W-1:0] sum);
        logic signed [SUM_W-1:0] scaled;
        logic [7:0]              clipped;
        scaled = sum >>> 7;
        if (scaled > 127) begin
            clipped = 8'h7f;
        end else if (scaled < -128) begin
            clipped = 8'h80;
        end else begin
            clipped = scaled[7:0];
        end
        return {~clipped[7], clipped[6:0]};
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NCHAN; i++) begin
                prod_l[i] <= '0;
                prod_r[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NCHAN; i++) begin
                prod_l[i] <= sample_i[i] * $signed({1'b0, vol_l_i[i]});
                prod_r[i] <= sample_i[i] * $signed({1'b0, vol_r_i[i]});
            end
        end
    end

    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int i = 0; i < NCHAN; i++) begin
            sum_l = sum_l + prod_l[i];
            sum_r = sum_r + prod_r[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_l_o <= {1'b1, {(`AUDIO_DAC_W-1){1'b0}}};    // mid scale
            out_r_o <= {1'b1, {(`AUDIO_DAC_W-1){1'b0}}};
        end else begin
            out_l_o <= to_dac(sum_l);
            out_r_o <= to_dac(sum_r);
        end
    end

endmodule

/* hdl/audio_channel.sv */
//**************************************************************************
// audio_channel
//   period counter setting the playback rate
//   length counter and address register with reload from settings
//   two-sample word buffer and current output sample
//**************************************************************************

`timescale 1ns/100ps

module audio_channel (
    input  logic                    clk,
    input  logic                    reset_i,
    input  audio_pkg::chan_cfg_t    cfg_i,
    input  logic                    grant_i,
    input  audio_pkg::word_t        word_i,
    output logic                    want_o,
    output audio_pkg::mem_req_t     req_o,
    output audio_pkg::sample_t      sample_o,
    output logic                    reload_o
);

    audio_pkg::period_t period_cnt;
    audio_pkg::len_t    len_cnt;        // words left in this pass
    audio_pkg::addr_t   addr_q;
    logic               tile_q;
    audio_pkg::word_t   buf_q;
    logic               second_q;       // next advance takes the low byte
    logic               advance;
    logic               run_out;

    assign advance = cfg_i.enable && ((period_cnt == '0) || cfg_i.restart);
    assign run_out = (len_cnt == '0) || cfg_i.restart;

    assign req_o.tile = tile_q;
    assign req_o.addr = addr_q;

    // one advance every period+1 cycles
    always_ff @(posedge clk) begin
        if (reset_i) begin
            period_cnt <= '0;
        end else if (!cfg_i.enable || advance) begin
            period_cnt <= cfg_i.period;
        end else begin
            period_cnt <= period_cnt - 1'b1;
        end
    end

    // sample output and word buffer
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sample_o <= '0;
            buf_q    <= '0;
        end else begin
            if (advance) begin
                sample_o <= buf_q[15:8];
                buf_q    <= {buf_q[7:0], buf_q[7:0]};   // low byte repeats on underrun
            end
            if (grant_i) begin
                buf_q <= word_i;
            end
            if (!cfg_i.enable) begin
                sample_o <= '0;                         // silent when off
            end
        end
    end

    // word sequencing, once per two samples
    always_ff @(posedge clk) begin
        if (reset_i) begin
            second_q <= 1'b0;
            len_cnt  <= '0;         // first word step is a reload
            want_o   <= 1'b0;
            reload_o <= 1'b0;
        end else begin
            reload_o <= 1'b0;
            if (grant_i) begin
                want_o <= 1'b0;
            end
            if (!cfg_i.enable) begin
                second_q <= 1'b0;
                len_cnt  <= '0;
                want_o   <= 1'b0;
            end else if (advance) begin
                second_q <= !second_q;
                if (second_q) begin
                    want_o <= 1'b1;             // a new need wins over a grant
                    if (run_out) begin
                        len_cnt  <= cfg_i.len;
                        reload_o <= 1'b1;
                    end else begin
                        len_cnt <= len_cnt - 1'b1;
                    end
                end
            end
        end
    end

    // fetch address of the next word
    always_ff @(posedge clk) begin
        if (advance && second_q) begin
            if (run_out) begin
                addr_q <= cfg_i.start;
                tile_q <= cfg_i.tile;
            end else begin
                addr_q <= addr_q + 1'b1;
            end
        end
    end

endmodule

/* hdl/audio_fetch_ctrl.sv */
//**************************************************************************
// audio_fetch_ctrl
//   round-robin arbiter for channel word requests
//   request/acknowledge FSM on the shared memory read port
//   one-cycle grant of the returned word to the requesting channel
//**************************************************************************

`timescale 1ns/100ps
`include "audio_defines.svh"

module audio_fetch_ctrl (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic [`AUDIO_NCHAN-1:0]         want_i,
    input  audio_pkg::mem_req_t             req_i [`AUDIO_NCHAN],
    output logic [`AUDIO_NCHAN-1:0]         grant_o,
    output audio_pkg::word_t                word_o,
    output logic                            mem_fetch_o,
    output audio_pkg::mem_req_t             mem_req_o,
    input  logic                            mem_ack_i,
    input  audio_pkg::word_t                mem_word_i
);

    localparam int NCHAN = `AUDIO_NCHAN;
    localparam int IDX_W = (NCHAN > 1) ? $clog2(NCHAN) : 1;

    audio_pkg::fetch_state_t state;
    logic [IDX_W-1:0]        rr_ptr;        // first channel to look at
    logic [IDX_W-1:0]        sel_q;         // channel being served
    logic [IDX_W-1:0]        pick;
    logic                    pick_valid;

    // nearest wanting channel at or after the pointer
    always_comb begin : pick_next
        int j;
        pick       = rr_ptr;
        pick_valid = 1'b0;
        for (int k = NCHAN - 1; k >= 0; k--) begin
            j = int'(rr_ptr) + k;
            if (j >= NCHAN) begin
                j = j - NCHAN;
            end
            if (want_i[j]) begin
                pick       = IDX_W'(j);
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= audio_pkg::IDLE;
            mem_fetch_o <= 1'b0;
            rr_ptr      <= '0;
            sel_q       <= '0;
        end else begin
            case (state)
                audio_pkg::IDLE: begin
                    if (pick_valid) begin
                        sel_q <= pick;
                        state <= audio_pkg::ISSUE;
                    end
                end
                audio_pkg::ISSUE: begin
                    mem_fetch_o <= 1'b1;        // request registered below
                    state       <= audio_pkg::WAIT_ACK;
                end
                audio_pkg::WAIT_ACK: begin
                    if (mem_ack_i) begin
                        mem_fetch_o <= 1'b0;
                        rr_ptr      <= (int'(sel_q) == NCHAN - 1) ? '0 : sel_q + 1'b1;
                        state       <= audio_pkg::IDLE;
                    end
                end
                default: state <= audio_pkg::IDLE;
            endcase
        end
    end

    // held stable for the whole handshake
    always_ff @(posedge clk) begin
        if (state == audio_pkg::ISSUE) begin
            mem_req_o <= req_i[sel_q];
        end
    end

    // word is valid in the ack cycle, pass it on with the grant
    always_comb begin
        grant_o = '0;
        if (state == audio_pkg::WAIT_ACK && mem_ack_i) begin
            grant_o[sel_q] = 1'b1;
        end
    end

    assign word_o = mem_word_i;

endmodule

/* hdl/audio_pkg.sv */
//**************************************************************************
// audio_pkg
//   vector types for addresses, words, samples, volumes and DAC values
//   per-channel settings struct and memory request struct
//   fetch controller state encoding
//**************************************************************************

`include "audio_defines.svh"

package audio_pkg;

    typedef logic [`AUDIO_ADDR_W-1:0]   addr_t;     // memory word address
    typedef logic [15:0]                word_t;     // two samples, high byte first
    typedef logic signed [7:0]          sample_t;
    typedef logic [6:0]                 vol_t;      // 127 is close to unity
    typedef logic [`AUDIO_DAC_W-1:0]    dac_t;      // 128 is silence
    typedef logic [`AUDIO_PERIOD_W-1:0] period_t;
    typedef logic [`AUDIO_LEN_W-1:0]    len_t;

    // settings of one channel, written by the host
    typedef struct packed {
        logic    enable;
        logic    restart;   // force reload of start and len
        logic    tile;      // memory bank select
        vol_t    vol_l;
        vol_t    vol_r;
        period_t period;    // cycles per sample minus one
        addr_t   start;
        len_t    len;       // words per pass minus one
    } chan_cfg_t;

    typedef struct packed {
        logic  tile;
        addr_t addr;
    } mem_req_t;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        ISSUE    = 2'd1,
        WAIT_ACK = 2'd2
    } fetch_state_t;

endpackage

/* hdl/audio_defines.svh */
//**************************************************************************
// build-time sizes for the sampled audio mixer
//   channel count, memory address width, period and length
//   field widths, DAC sample width
//**************************************************************************

`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

`define AUDIO_NCHAN     2       // number of sample channels
`define AUDIO_ADDR_W    16      // memory word address
`define AUDIO_PERIOD_W  15      // playback period field
`define AUDIO_LEN_W     15      // sample length field, in words
`define AUDIO_DAC_W     8       // offset-binary DAC value

`endif
